// ==== source/ref_mem_pkg.sv ====
package ref_mem_pkg;

	// bank array geometry
	localparam int num_banks = 32;
	localparam int row_w = 7;
	localparam int shift_w = 5;

	// preload layout of 8 groups with 4 banks each
	localparam int group_banks = 4;
	localparam int num_groups = 8;
	localparam int rows_per_group = 96;
	localparam int preload_cycles = num_groups * rows_per_group;

	// search sub-area 1
	localparam int num_columns = 7;
	localparam int rows_per_pass = 24;
	localparam int pair_offset = 24;
	localparam int column_step = 8;

	// rows that are read twice for reference reuse
	localparam int stall_first = 7;
	localparam int stall_last = 19;

	typedef enum logic [1:0] {
		phase_idle,
		phase_preload,
		phase_search
	} phase_t;

endpackage

// ==== source/ref_phase_seq.sv ====
`timescale 1ns/1ps

module ref_phase_seq (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic preload_last,
	input  logic scan_last,
	input  logic rd_en,
	output logic preload_run,
	output logic scan_run,
	output logic busy
);

	ref_mem_pkg::phase_t state;
	logic drain;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ref_mem_pkg::phase_idle;
			drain <= 1'b0;
		end else begin
			case (state)
				ref_mem_pkg::phase_idle: begin
					drain <= 1'b0;
					if (start) begin
						state <= ref_mem_pkg::phase_preload;
					end
				end
				ref_mem_pkg::phase_preload: begin
					if (preload_last) begin
						state <= ref_mem_pkg::phase_search;
					end
				end
				ref_mem_pkg::phase_search: begin
					// hold search until the mapped copy of the last entry is out
					if (drain && rd_en) begin
						state <= ref_mem_pkg::phase_idle;
						drain <= 1'b0;
					end else if (scan_last) begin
						drain <= 1'b1;
					end
				end
				default: begin
					state <= ref_mem_pkg::phase_idle;
					drain <= 1'b0;
				end
			endcase
		end
	end

	// busy trails the phase by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else begin
			busy <= (state != ref_mem_pkg::phase_idle);
		end
	end

	assign preload_run = (state == ref_mem_pkg::phase_preload);
	assign scan_run = (state == ref_mem_pkg::phase_search);

	run_exclusive_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(preload_run && scan_run)
	);

endmodule

// ==== source/preload_addr_gen.sv ====
`timescale 1ns/1ps

module preload_addr_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic preload_run,
	output logic wr_en,
	output logic [ref_mem_pkg::num_banks-1:0] bank_sel,
	output logic [ref_mem_pkg::row_w-1:0] wr_row,
	output logic preload_last
);

	localparam logic [ref_mem_pkg::num_banks-1:0] first_mask =
		{{(ref_mem_pkg::num_banks - ref_mem_pkg::group_banks){1'b0}},
		{ref_mem_pkg::group_banks{1'b1}}};

	logic [$clog2(ref_mem_pkg::preload_cycles + 1)-1:0] wr_cnt;
	logic [ref_mem_pkg::row_w-1:0] row_cnt;
	logic [ref_mem_pkg::num_banks-1:0] mask;
	logic [ref_mem_pkg::num_groups-1:0] grp_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cnt <= '0;
			row_cnt <= '0;
			mask <= first_mask;
			wr_en <= 1'b0;
			bank_sel <= '0;
			wr_row <= '0;
			preload_last <= 1'b0;
		end else if (preload_run && (wr_cnt != ref_mem_pkg::preload_cycles)) begin
			wr_en <= 1'b1;
			bank_sel <= mask;
			wr_row <= row_cnt;
			preload_last <= (wr_cnt == ref_mem_pkg::preload_cycles - 1);
			wr_cnt <= wr_cnt + 1'b1;
			// next group of four banks every 96 rows
			if (row_cnt == ref_mem_pkg::rows_per_group - 1) begin
				row_cnt <= '0;
				mask <= mask << ref_mem_pkg::group_banks;
			end else begin
				row_cnt <= row_cnt + 1'b1;
			end
		end else begin
			wr_en <= 1'b0;
			bank_sel <= '0;
			wr_row <= '0;
			preload_last <= 1'b0;
			// rearm for the next run once the phase has dropped
			if (!preload_run) begin
				wr_cnt <= '0;
				row_cnt <= '0;
				mask <= first_mask;
			end
		end
	end

	always_comb begin
		for (int g = 0; g < ref_mem_pkg::num_groups; g++) begin
			grp_full[g] = &bank_sel[g*ref_mem_pkg::group_banks +: ref_mem_pkg::group_banks];
		end
	end

	group_select_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en |-> ($countones(bank_sel) == ref_mem_pkg::group_banks) && $onehot(grp_full)
	);

endmodule

// ==== source/search_scan_gen.sv ====
`timescale 1ns/1ps

module search_scan_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic scan_run,
	output logic scan_valid,
	output logic [ref_mem_pkg::row_w-1:0] scan_row,
	output logic [ref_mem_pkg::row_w-1:0] scan_base,
	output logic [ref_mem_pkg::shift_w-1:0] scan_shift,
	output logic scan_last
);

	logic [2:0] col_cnt;
	logic pair;
	logic [$clog2(ref_mem_pkg::rows_per_pass)-1:0] row_cnt;
	logic stall;
	logic done;

	logic in_reuse;
	logic pass_end;
	logic [ref_mem_pkg::row_w-1:0] col_offset;
	logic [ref_mem_pkg::row_w-1:0] win_base;
	logic [ref_mem_pkg::row_w-1:0] pair_add;

	assign in_reuse = (row_cnt >= ref_mem_pkg::stall_first) &&
		(row_cnt <= ref_mem_pkg::stall_last);
	assign pass_end = (row_cnt == ref_mem_pkg::rows_per_pass - 1);

	assign scan_valid = scan_run && !done;
	assign scan_last = scan_valid && pass_end && pair &&
		(col_cnt == ref_mem_pkg::num_columns);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_cnt <= 3'd1;
			pair <= 1'b0;
			row_cnt <= '0;
			stall <= 1'b0;
			done <= 1'b0;
		end else if (!scan_run) begin
			col_cnt <= 3'd1;
			pair <= 1'b0;
			row_cnt <= '0;
			stall <= 1'b0;
			done <= 1'b0;
		end else if (scan_valid) begin
			if (in_reuse && !stall) begin
				// repeat this row once
				stall <= 1'b1;
			end else begin
				stall <= 1'b0;
				if (pass_end) begin
					row_cnt <= '0;
					pair <= !pair;
					if (pair) begin
						col_cnt <= col_cnt + 3'd1;
					end
					if (scan_last) begin
						done <= 1'b1;
					end
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
		end
	end

	// window offset in banks is (col - 1) * 8
	assign col_offset = ref_mem_pkg::row_w'((col_cnt - 3'd1) * ref_mem_pkg::column_step);
	assign scan_shift = col_offset[ref_mem_pkg::shift_w-1:0];

	// offset past the bank count moves the window down one block
	assign win_base = (col_offset >= ref_mem_pkg::num_banks) ?
		ref_mem_pkg::row_w'(ref_mem_pkg::pair_offset) : '0;
	assign pair_add = pair ? ref_mem_pkg::row_w'(ref_mem_pkg::pair_offset) : '0;

	assign scan_base = win_base + pair_add;
	assign scan_row = ref_mem_pkg::row_w'(row_cnt);

	shift_step_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		scan_valid |-> (scan_shift % ref_mem_pkg::column_step) == 0
	);

endmodule

// ==== source/bank_addr_map.sv ====
`timescale 1ns/1ps

module bank_addr_map (
	input  logic clk,
	input  logic rst_n,
	input  logic scan_valid,
	input  logic [ref_mem_pkg::row_w-1:0] scan_row,
	input  logic [ref_mem_pkg::row_w-1:0] scan_base,
	input  logic [ref_mem_pkg::shift_w-1:0] scan_shift,
	output logic rd_en,
	output logic [ref_mem_pkg::num_banks*ref_mem_pkg::row_w-1:0] rd_addr_all,
	output logic [ref_mem_pkg::shift_w-1:0] shift
);

	logic [ref_mem_pkg::num_banks*ref_mem_pkg::row_w-1:0] addr_next;
	logic [ref_mem_pkg::row_w-1:0] row_lo;
	logic [ref_mem_pkg::row_w-1:0] row_hi;

	assign row_lo = scan_base + scan_row;
	assign row_hi = row_lo + ref_mem_pkg::row_w'(ref_mem_pkg::pair_offset);

	// banks left of the shift have wrapped, so they read one block lower
	always_comb begin
		for (int b = 0; b < ref_mem_pkg::num_banks; b++) begin
			if (b < scan_shift) begin
				addr_next[b*ref_mem_pkg::row_w +: ref_mem_pkg::row_w] = row_hi;
			end else begin
				addr_next[b*ref_mem_pkg::row_w +: ref_mem_pkg::row_w] = row_lo;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_en <= 1'b0;
			rd_addr_all <= '0;
			shift <= '0;
		end else begin
			rd_en <= scan_valid;
			rd_addr_all <= scan_valid ? addr_next : '0;
			shift <= scan_valid ? scan_shift : '0;
		end
	end

	for (genvar b = 0; b < ref_mem_pkg::num_banks; b++) begin : g_row_chk
		bank_row_range_a: assert property (
			@(posedge clk) disable iff (!rst_n)
			rd_en |-> rd_addr_all[b*ref_mem_pkg::row_w +: ref_mem_pkg::row_w] <
				ref_mem_pkg::rows_per_group
		);
	end

endmodule

// ==== source/ref_mem_ctrl.sv ====
`timescale 1ns/1ps

module ref_mem_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic wr_en,
	output logic [ref_mem_pkg::num_banks-1:0] bank_sel,
	output logic [ref_mem_pkg::row_w-1:0] wr_row,
	output logic rd_en,
	output logic [ref_mem_pkg::num_banks*ref_mem_pkg::row_w-1:0] rd_addr_all,
	output logic [ref_mem_pkg::shift_w-1:0] shift,
	output logic busy
);

	logic preload_run;
	logic scan_run;
	logic preload_last;
	logic scan_last;

	// scanner to address map
	logic scan_valid;
	logic [ref_mem_pkg::row_w-1:0] scan_row;
	logic [ref_mem_pkg::row_w-1:0] scan_base;
	logic [ref_mem_pkg::shift_w-1:0] scan_shift;

	ref_phase_seq seq_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.preload_last(preload_last),
		.scan_last(scan_last),
		.rd_en(rd_en),
		.preload_run(preload_run),
		.scan_run(scan_run),
		.busy(busy)
	);

	preload_addr_gen preload_i (
		.clk(clk),
		.rst_n(rst_n),
		.preload_run(preload_run),
		.wr_en(wr_en),
		.bank_sel(bank_sel),
		.wr_row(wr_row),
		.preload_last(preload_last)
	);

	search_scan_gen scan_i (
		.clk(clk),
		.rst_n(rst_n),
		.scan_run(scan_run),
		.scan_valid(scan_valid),
		.scan_row(scan_row),
		.scan_base(scan_base),
		.scan_shift(scan_shift),
		.scan_last(scan_last)
	);

	bank_addr_map map_i (
		.clk(clk),
		.rst_n(rst_n),
		.scan_valid(scan_valid),
		.scan_row(scan_row),
		.scan_base(scan_base),
		.scan_shift(scan_shift),
		.rd_en(rd_en),
		.rd_addr_all(rd_addr_all),
		.shift(shift)
	);

endmodule

// ==== verification/tb_ref_mem_ctrl.sv ====
`timescale 1ns/1ps

module tb_ref_mem_ctrl;

	localparam int clk_period = 40;
	localparam int reset_cycles = 16;
	localparam int run_span = 1300;
	localparam int watchdog_margin = 400;
	localparam int max_runs = 15;
	localparam int max_reads = 1024;

	logic clk;
	logic rst_n;
	logic start;
	logic wr_en;
	logic [ref_mem_pkg::num_banks-1:0] bank_sel;
	logic [ref_mem_pkg::row_w-1:0] wr_row;
	logic rd_en;
	logic [ref_mem_pkg::num_banks*ref_mem_pkg::row_w-1:0] rd_addr_all;
	logic [ref_mem_pkg::shift_w-1:0] shift;
	logic busy;

	// word 0 holds the run count and each run takes four words
	logic [15:0] stim_mem [0:4*max_runs];
	int num_runs;
	bit stim_loaded;
	integer seed;

	// expected reads in issue order
	int model_row [0:max_reads-1];
	int model_shift [0:max_reads-1];
	int model_count;

	int mismatches;
	int other_errors;

	ref_mem_ctrl dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.wr_en(wr_en),
		.bank_sel(bank_sel),
		.wr_row(wr_row),
		.rd_en(rd_en),
		.rd_addr_all(rd_addr_all),
		.shift(shift),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	task automatic report_mismatch(input string what, input logic [255:0] got,
		input logic [255:0] expected);
		mismatches++;
		$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
	endtask

	// column outermost and row innermost with rows 7..19 doubled
	task automatic build_read_model();
		int offset;
		int base;
		int pair_add;
		int repeats;
		model_count = 0;
		for (int c = 1; c <= ref_mem_pkg::num_columns; c++) begin
			offset = (c - 1) * ref_mem_pkg::column_step;
			base = (offset >= ref_mem_pkg::num_banks) ? ref_mem_pkg::pair_offset : 0;
			for (int p = 0; p < 2; p++) begin
				pair_add = (p == 1) ? ref_mem_pkg::pair_offset : 0;
				for (int r = 0; r < ref_mem_pkg::rows_per_pass; r++) begin
					repeats = 1;
					if (r >= ref_mem_pkg::stall_first && r <= ref_mem_pkg::stall_last) begin
						repeats = 2;
					end
					for (int i = 0; i < repeats; i++) begin
						model_row[model_count] = base + pair_add + r;
						model_shift[model_count] = offset % ref_mem_pkg::num_banks;
						model_count++;
					end
				end
			end
		end
	endtask

	task automatic check_idle(input bit full);
		if (wr_en !== 1'b0) report_mismatch("idle wr_en", wr_en, 0);
		if (rd_en !== 1'b0) report_mismatch("idle rd_en", rd_en, 0);
		if (busy !== 1'b0) report_mismatch("idle busy", busy, 0);
		if (full) begin
			if (bank_sel !== '0) report_mismatch("idle bank_sel", bank_sel, 0);
			if (wr_row !== '0) report_mismatch("idle wr_row", wr_row, 0);
			if (rd_addr_all !== '0) report_mismatch("idle rd_addr_all", rd_addr_all, 0);
			if (shift !== '0) report_mismatch("idle shift", shift, 0);
		end
	endtask

	initial begin
		int t;
		int n_wr;
		int n_rd;
		int gap;
		int stray;
		int exp_row;
		int rd_first;
		int rd_last;
		bit exp_wr;
		bit exp_rd;
		bit exp_busy;
		logic [ref_mem_pkg::num_banks-1:0] exp_sel;
		logic [ref_mem_pkg::row_w-1:0] bank_row;
		rst_n = 1'b0;
		start = 1'b0;
		seed = 32'hfc54;
		mismatches = 0;
		other_errors = 0;
		$readmemh("verification/ref_mem_stimulus.dat", stim_mem);
		num_runs = stim_mem[0];
		if (num_runs < 1 || num_runs > max_runs) begin
			other_errors++;
			$display("the stimulus file holds no usable run count (%0d)", num_runs);
			num_runs = 0;
		end
		stim_loaded = 1'b1;
		build_read_model();
		rd_first = ref_mem_pkg::preload_cycles + 2;
		rd_last = rd_first + model_count - 1;

		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle(1'b1);

		for (int run = 0; run < num_runs; run++) begin
			gap = stim_mem[1 + 4*run];
			stray = stim_mem[2 + 4*run];
			repeat (gap) begin
				@(posedge clk);
				@(negedge clk);
				check_idle(($random(seed) & 3) == 0);
			end
			@(posedge clk);
			start <= 1'b1;
			@(negedge clk);
			check_idle(1'b0);

			// t counts edges after the one that samples start
			t = 0;
			n_wr = 0;
			n_rd = 0;
			do begin
				@(posedge clk);
				start <= (stray != 0) && (t == stray - 1);
				@(negedge clk);
				exp_wr = (t >= 1) && (t <= ref_mem_pkg::preload_cycles);
				exp_rd = (t >= rd_first) && (t <= rd_last);
				exp_busy = (t >= 1) && (t <= rd_last + 1);
				if (wr_en !== exp_wr) begin
					report_mismatch($sformatf("wr_en at t=%0d", t), wr_en, exp_wr);
				end
				if (rd_en !== exp_rd) begin
					report_mismatch($sformatf("rd_en at t=%0d", t), rd_en, exp_rd);
				end
				if (busy !== exp_busy) begin
					report_mismatch($sformatf("busy at t=%0d", t), busy, exp_busy);
				end
				if (wr_en === 1'b1) begin
					exp_sel = 32'hf << (4 * (n_wr / 96));
					if (bank_sel !== exp_sel) begin
						report_mismatch($sformatf("bank_sel of write %0d", n_wr), bank_sel,
							exp_sel);
					end
					if (wr_row !== n_wr % 96) begin
						report_mismatch($sformatf("wr_row of write %0d", n_wr), wr_row,
							n_wr % 96);
					end
					n_wr++;
				end
				if (rd_en === 1'b1 && n_rd < model_count) begin
					if (shift !== model_shift[n_rd]) begin
						report_mismatch($sformatf("shift of read %0d", n_rd), shift,
							model_shift[n_rd]);
					end
					for (int b = 0; b < ref_mem_pkg::num_banks; b++) begin
						exp_row = model_row[n_rd];
						if (b < model_shift[n_rd]) begin
							exp_row += 24;
						end
						bank_row = rd_addr_all[b*ref_mem_pkg::row_w +: ref_mem_pkg::row_w];
						if (bank_row !== exp_row) begin
							report_mismatch($sformatf("read %0d bank %0d row", n_rd, b),
								bank_row, exp_row);
						end
					end
				end
				if (rd_en === 1'b1) n_rd++;
				t++;
			end while (t == 1 || busy === 1'b1);

			if (n_wr != stim_mem[3 + 4*run]) begin
				report_mismatch("write total", n_wr, stim_mem[3 + 4*run]);
			end
			if (n_rd != stim_mem[4 + 4*run]) begin
				report_mismatch("read total", n_rd, stim_mem[4 + 4*run]);
			end
		end

		$display("mismatches %0d, other errors %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// limit follows the gaps and run count in the stimulus file
	initial begin
		int limit;
		wait (stim_loaded);
		limit = reset_cycles + watchdog_margin;
		for (int run = 0; run < num_runs; run++) begin
			limit += stim_mem[1 + 4*run] + run_span;
		end
		repeat (limit) @(posedge clk);
		other_errors++;
		$display("timeout: the controller did not finish its runs within %0d cycles", limit);
		$display("mismatches %0d, other errors %0d", mismatches, other_errors);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verification/ref_mem_stimulus.dat ====
// runs for tb_ref_mem_ctrl, all values hex, first word is the run count
// per run: idle gap, stray start offset in busy cycles (0 is none), write total, read total
0006
0004 0005 0300 0206
0000 0302 0300 0206
0011 0508 0300 0206
0002 0000 0300 0206
0007 0300 0300 0206
0001 0301 0300 0206

// ==== build.f ====
source/ref_mem_pkg.sv
source/ref_phase_seq.sv
source/preload_addr_gen.sv
source/search_scan_gen.sv
source/bank_addr_map.sv
source/ref_mem_ctrl.sv
verification/tb_ref_mem_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ref_mem_ctrl
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "no result in $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
